// File: hdl/core_isa_pkg.sv
package core_isa_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE
    } br_kind_t;

    typedef struct packed {
        alu_op_t    alu_op;
        br_kind_t   br_kind;
        logic       use_imm;
        logic       rf_wen;
        logic [4:0] wb_addr;
        logic       is_ecall;
    } ctrl_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_SUB   = 3'b000;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;
    localparam logic [2:0] F3_ECALL = 3'b000;

    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;
    localparam logic [6:0] F7_XOR = 7'b0000000;
    localparam logic [6:0] F7_OR  = 7'b0000000;
    localparam logic [6:0] F7_AND = 7'b0000000;

endpackage

// File: hdl/core_pipe_pkg.sv
package core_pipe_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } dec_payload_t;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        core_isa_pkg::ctrl_t ctrl;
        logic [XLEN-1:0]     rs1_val;
        logic [XLEN-1:0]     rs2_val;
        logic [XLEN-1:0]     imm;
    } exe_payload_t;

    typedef struct packed {
        core_isa_pkg::ctrl_t ctrl;
        logic [XLEN-1:0]     result;
    } wb_payload_t;

endpackage

// File: hdl/stage_link.sv
`timescale 1ns/1ps

interface stage_link #(
    parameter type payload_t = logic
);

    logic     valid;
    payload_t payload;
    // flow back from the younger side
    logic     stall;
    logic     kill;

    modport producer (output valid, output payload, input stall, input kill);

    modport consumer (input valid, input payload, output stall, output kill);

endinterface

// File: hdl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input logic         clk,
    input logic         reset,
    stage_link.consumer in_link,
    stage_link.producer out_link
);

    logic     valid_q;
    payload_t payload_q;

    // kill wins over stall
    always_ff @(posedge clk) begin
        if (reset || out_link.kill) begin
            valid_q <= 1'b0;
        end else if (!out_link.stall) begin
            valid_q <= in_link.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_link.stall) begin
            payload_q <= in_link.payload;
        end
    end

    assign out_link.valid   = valid_q;
    assign out_link.payload = payload_q;

    assign in_link.stall = out_link.stall;
    assign in_link.kill  = out_link.kill;

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                           clk,
    input  logic                           reset,
    output logic [core_pipe_pkg::XLEN-1:0] imem_addr,
    input  logic [core_pipe_pkg::XLEN-1:0] imem_rdata,
    input  logic                           redirect_valid,
    input  logic [core_pipe_pkg::XLEN-1:0] redirect_pc,
    stage_link.producer                    dec_link,
    input  logic                           halt
);

    import core_pipe_pkg::*;

    logic [XLEN-1:0] issue_pc;
    logic [XLEN-1:0] arrive_pc;
    logic            arrive_valid;
    dec_payload_t    fetched;

    // word not taken by decode is fetched again
    assign imem_addr = dec_link.stall ? arrive_pc : issue_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_pc     <= RESET_PC;
            arrive_valid <= 1'b0;
        end else if (halt) begin
            arrive_valid <= 1'b0;
        end else if (redirect_valid) begin
            // word issued this cycle is on the wrong path
            issue_pc     <= redirect_pc;
            arrive_valid <= 1'b0;
        end else if (!dec_link.stall) begin
            issue_pc     <= issue_pc + XLEN'(4);
            arrive_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!dec_link.stall) begin
            arrive_pc <= issue_pc;
        end
    end

    assign fetched.pc   = arrive_pc;
    assign fetched.inst = imem_rdata;

    assign dec_link.valid   = arrive_valid;
    assign dec_link.payload = fetched;

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    stage_link.consumer                          dec_link,
    stage_link.producer                          exe_link,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [core_pipe_pkg::XLEN-1:0]       rs1_data,
    input  logic [core_pipe_pkg::XLEN-1:0]       rs2_data,
    input  core_isa_pkg::ctrl_t                  exe_ctrl,
    input  logic                                 exe_valid,
    input  core_isa_pkg::ctrl_t                  wb_ctrl,
    input  logic                                 wb_valid
);

    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    logic [XLEN-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            reads_rs1;
    logic            reads_rs2;
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic            hazard;
    exe_payload_t    exe_payload;

    function automatic logic writes_reg(input logic valid, input ctrl_t c,
                                        input logic [REG_ADDR_W-1:0] addr);
        return valid && c.rf_wen && (c.wb_addr != '0) && (c.wb_addr == addr);
    endfunction

    assign inst   = dec_link.payload.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl         = '0;
        ctrl.wb_addr = inst[11:7];
        imm          = '0;
        reads_rs1    = 1'b0;
        reads_rs2    = 1'b0;
        case (opcode)
            OP_REG: begin
                reads_rs1   = 1'b1;
                reads_rs2   = 1'b1;
                ctrl.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {F7_ADD, F3_ADD}: ctrl.alu_op = ALU_ADD;
                    {F7_SUB, F3_SUB}: ctrl.alu_op = ALU_SUB;
                    {F7_XOR, F3_XOR}: ctrl.alu_op = ALU_XOR;
                    {F7_OR, F3_OR}:   ctrl.alu_op = ALU_OR;
                    {F7_AND, F3_AND}: ctrl.alu_op = ALU_AND;
                    default:          ctrl.rf_wen = 1'b0;
                endcase
            end
            OP_IMM: begin
                reads_rs1    = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = (funct3 == F3_ADDI);
                imm          = {{20{inst[31]}}, inst[31:20]};
            end
            OP_LUI: begin
                ctrl.alu_op  = ALU_PASS_IMM;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = 1'b1;
                imm          = {inst[31:12], 12'b0};
            end
            OP_BRANCH: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                imm       = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                if (funct3 == F3_BEQ) begin
                    ctrl.br_kind = BR_BEQ;
                end else if (funct3 == F3_BNE) begin
                    ctrl.br_kind = BR_BNE;
                end
            end
            OP_SYSTEM: begin
                ctrl.is_ecall = (funct3 == F3_ECALL) && (inst[31:20] == 12'h000);
            end
            default: ;
        endcase
    end

    // unread operands go to x0 so they never cause a stall
    assign rs1_addr = reads_rs1 ? inst[19:15] : '0;
    assign rs2_addr = reads_rs2 ? inst[24:20] : '0;

    assign hazard = dec_link.valid &&
                    (writes_reg(exe_valid, exe_ctrl, rs1_addr) ||
                     writes_reg(exe_valid, exe_ctrl, rs2_addr) ||
                     writes_reg(wb_valid, wb_ctrl, rs1_addr) ||
                     writes_reg(wb_valid, wb_ctrl, rs2_addr));

    assign exe_payload.pc      = dec_link.payload.pc;
    assign exe_payload.ctrl    = ctrl;
    assign exe_payload.rs1_val = rs1_data;
    assign exe_payload.rs2_val = rs2_data;
    assign exe_payload.imm     = imm;

    // bubble into execute while stalled
    assign exe_link.valid   = dec_link.valid && !hazard;
    assign exe_link.payload = exe_payload;

    assign dec_link.stall = hazard || exe_link.stall;
    assign dec_link.kill  = exe_link.kill;

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    stage_link.consumer                    exe_link,
    stage_link.producer                    wb_link,
    output logic                           redirect_valid,
    output logic [core_pipe_pkg::XLEN-1:0] redirect_pc
);

    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    exe_payload_t    ex;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] result;
    logic            operands_equal;
    logic            taken;
    wb_payload_t     wb_payload;

    assign ex        = exe_link.payload;
    assign operand_b = ex.ctrl.use_imm ? ex.imm : ex.rs2_val;

    always_comb begin
        case (ex.ctrl.alu_op)
            ALU_ADD:      result = ex.rs1_val + operand_b;
            ALU_SUB:      result = ex.rs1_val - operand_b;
            ALU_AND:      result = ex.rs1_val & operand_b;
            ALU_OR:       result = ex.rs1_val | operand_b;
            ALU_XOR:      result = ex.rs1_val ^ operand_b;
            ALU_PASS_IMM: result = ex.imm;
            default:      result = '0;
        endcase
    end

    assign operands_equal = (ex.rs1_val == ex.rs2_val);

    always_comb begin
        case (ex.ctrl.br_kind)
            BR_BEQ:  taken = operands_equal;
            BR_BNE:  taken = !operands_equal;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_valid = exe_link.valid && taken;
    assign redirect_pc    = ex.pc + ex.imm;

    always_comb begin
        wb_payload             = '0;
        wb_payload.ctrl        = ex.ctrl;
        wb_payload.ctrl.rf_wen = ex.ctrl.rf_wen && (ex.ctrl.br_kind == BR_NONE);
        wb_payload.result      = result;
    end

    assign wb_link.valid   = exe_link.valid;
    assign wb_link.payload = wb_payload;

    // a taken branch flushes decode and the arriving fetch word
    assign exe_link.stall = wb_link.stall;
    assign exe_link.kill  = redirect_valid || wb_link.kill;

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    stage_link.consumer                          wb_link,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pipe_pkg::XLEN-1:0]       rs1_data,
    output logic [core_pipe_pkg::XLEN-1:0]       rs2_data,
    output logic                                 retire_valid,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] retire_addr,
    output logic [core_pipe_pkg::XLEN-1:0]       retire_data,
    output logic                                 exit
);

    import core_pipe_pkg::*;

    logic [XLEN-1:0] regs [1:31];
    wb_payload_t     wb;
    logic            wen;

    // write-through so decode sees this cycle's result
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wen && (wb.ctrl.wb_addr == addr)) begin
            return wb.result;
        end
        return regs[addr];
    endfunction

    assign wb  = wb_link.payload;
    assign wen = wb_link.valid && wb.ctrl.rf_wen && (wb.ctrl.wb_addr != '0) && !exit;

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[wb.ctrl.wb_addr] <= wb.result;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            exit         <= 1'b0;
        end else begin
            retire_valid <= wen;
            if (wb_link.valid && wb.ctrl.is_ecall) begin
                exit <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            retire_addr <= wb.ctrl.wb_addr;
            retire_data <= wb.result;
        end
    end

    // drain everything behind the ecall
    assign wb_link.stall = 1'b0;
    assign wb_link.kill  = exit;

endmodule

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                                 clk,
    input  logic                                 reset,
    output logic [core_pipe_pkg::XLEN-1:0]       imem_addr,
    input  logic [core_pipe_pkg::XLEN-1:0]       imem_rdata,
    output logic                                 retire_valid,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] retire_addr,
    output logic [core_pipe_pkg::XLEN-1:0]       retire_data,
    output logic                                 exit
);

    import core_pipe_pkg::*;

    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    stage_link #(.payload_t(dec_payload_t)) fetch_to_dec_in ();
    stage_link #(.payload_t(dec_payload_t)) fetch_to_dec_out ();
    stage_link #(.payload_t(exe_payload_t)) dec_to_exe_in ();
    stage_link #(.payload_t(exe_payload_t)) dec_to_exe_out ();
    stage_link #(.payload_t(wb_payload_t))  exe_to_wb_in ();
    stage_link #(.payload_t(wb_payload_t))  exe_to_wb_out ();

    fetch_unit u_fetch (
        .clk            (clk),
        .reset          (reset),
        .imem_addr      (imem_addr),
        .imem_rdata     (imem_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dec_link       (fetch_to_dec_in),
        .halt           (exit)
    );

    pipe_reg #(.payload_t(dec_payload_t)) u_fetch_to_dec_reg (
        .clk      (clk),
        .reset    (reset),
        .in_link  (fetch_to_dec_in),
        .out_link (fetch_to_dec_out)
    );

    // hazard inputs come from the execute and writeback registers
    decode_stage u_decode (
        .dec_link  (fetch_to_dec_out),
        .exe_link  (dec_to_exe_in),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .exe_ctrl  (dec_to_exe_out.payload.ctrl),
        .exe_valid (dec_to_exe_out.valid),
        .wb_ctrl   (exe_to_wb_out.payload.ctrl),
        .wb_valid  (exe_to_wb_out.valid)
    );

    pipe_reg #(.payload_t(exe_payload_t)) u_dec_to_exe_reg (
        .clk      (clk),
        .reset    (reset),
        .in_link  (dec_to_exe_in),
        .out_link (dec_to_exe_out)
    );

    execute_stage u_execute (
        .exe_link       (dec_to_exe_out),
        .wb_link        (exe_to_wb_in),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    pipe_reg #(.payload_t(wb_payload_t)) u_exe_to_wb_reg (
        .clk      (clk),
        .reset    (reset),
        .in_link  (exe_to_wb_in),
        .out_link (exe_to_wb_out)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .reset        (reset),
        .wb_link      (exe_to_wb_out),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data),
        .exit         (exit)
    );

endmodule

// File: sim/core_sva.sv
`timescale 1ns/1ps

module core_sva (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 retire_valid,
    input logic [core_pipe_pkg::REG_ADDR_W-1:0] retire_addr,
    input logic                                 exit
);

    // x0 writes never reach the trace
    assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> (retire_addr != '0))
        else $error("retire trace shows register x0");

    // exit is a latch cleared only by reset
    assert property (@(posedge clk)
        (!reset && !$past(reset) && $past(exit)) |-> exit)
        else $error("exit dropped while reset was low");

    assert property (@(posedge clk) disable iff (reset)
        exit |-> !retire_valid)
        else $error("retire strobe seen after exit");

endmodule

bind core_top core_sva u_core_sva (
    .clk          (clk),
    .reset        (reset),
    .retire_valid (retire_valid),
    .retire_addr  (retire_addr),
    .exit         (exit)
);

// File: sim/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int NUM_PROGS   = 8;
    localparam int PROG_LEN    = 48;
    localparam int INIT_LEN    = 7;
    localparam int DRAIN       = 20;
    localparam int WATCHDOG_NS = NUM_PROGS * PROG_LEN * 4 * 10 + 2000;

    typedef enum logic [3:0] {
        I_ADD, I_SUB, I_AND, I_OR, I_XOR, I_ADDI, I_LUI, I_BEQ, I_BNE, I_ECALL
    } inst_kind_t;

    logic                  clk        = 1'b0;
    logic                  reset      = 1'b1;
    logic [XLEN-1:0]       imem_rdata = '0;
    logic [XLEN-1:0]       imem_addr;
    logic                  retire_valid;
    logic [REG_ADDR_W-1:0] retire_addr;
    logic [XLEN-1:0]       retire_data;
    logic                  exit;

    logic [31:0]           lcg_state = 32'h4475_3d5e;

    inst_kind_t            kind_of [0:PROG_LEN-1];
    logic [4:0]            rd_of   [0:PROG_LEN-1];
    logic [4:0]            rs1_of  [0:PROG_LEN-1];
    logic [4:0]            rs2_of  [0:PROG_LEN-1];
    logic [XLEN-1:0]       imm_of  [0:PROG_LEN-1];
    logic [XLEN-1:0]       word_of [0:PROG_LEN-1];

    // expected register writes in program order
    logic [REG_ADDR_W-1:0] exp_addr [$];
    logic [XLEN-1:0]       exp_data [$];

    core_top uut (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data),
        .exit         (exit)
    );

    always #5 clk = ~clk;

    // one cycle read latency
    always @(posedge clk) begin
        if (imem_addr < XLEN'(4 * PROG_LEN)) begin
            imem_rdata <= word_of[imem_addr[7:2]];
        end else begin
            // past the end of the program
            imem_rdata <= {12'h000, 5'd0, F3_ECALL, 5'd0, OP_SYSTEM};
        end
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [XLEN-1:0] encode(input int i);
        logic [XLEN-1:0] imm;
        imm = imm_of[i];
        case (kind_of[i])
            I_ADD:   return {F7_ADD, rs2_of[i], rs1_of[i], F3_ADD, rd_of[i], OP_REG};
            I_SUB:   return {F7_SUB, rs2_of[i], rs1_of[i], F3_SUB, rd_of[i], OP_REG};
            I_AND:   return {F7_AND, rs2_of[i], rs1_of[i], F3_AND, rd_of[i], OP_REG};
            I_OR:    return {F7_OR, rs2_of[i], rs1_of[i], F3_OR, rd_of[i], OP_REG};
            I_XOR:   return {F7_XOR, rs2_of[i], rs1_of[i], F3_XOR, rd_of[i], OP_REG};
            I_ADDI:  return {imm[11:0], rs1_of[i], F3_ADDI, rd_of[i], OP_IMM};
            I_LUI:   return {imm[31:12], rd_of[i], OP_LUI};
            I_BEQ:   return {imm[12], imm[10:5], rs2_of[i], rs1_of[i], F3_BEQ,
                             imm[4:1], imm[11], OP_BRANCH};
            I_BNE:   return {imm[12], imm[10:5], rs2_of[i], rs1_of[i], F3_BNE,
                             imm[4:1], imm[11], OP_BRANCH};
            default: return {12'h000, 5'd0, F3_ECALL, 5'd0, OP_SYSTEM};
        endcase
    endfunction

    task automatic build_program();
        logic [15:0] r;
        logic [15:0] r2;
        int          span;
        for (int i = 0; i < PROG_LEN; i++) begin
            r          = next_rand();
            r2         = next_rand();
            kind_of[i] = inst_kind_t'(4'(next_rand() % 16'd9));
            rd_of[i]   = {2'b00, r[2:0]};
            rs1_of[i]  = {2'b00, r[5:3]};
            rs2_of[i]  = {2'b00, r[8:6]};
            imm_of[i]  = {{20{r2[11]}}, r2[11:0]};
            if (i < INIT_LEN) begin
                // x1..x7 get known values first
                kind_of[i] = I_ADDI;
                rd_of[i]   = 5'(i + 1);
                rs1_of[i]  = '0;
            end else if (i == PROG_LEN - 1) begin
                kind_of[i] = I_ECALL;
            end else if (kind_of[i] == I_LUI) begin
                imm_of[i] = {r2, r[15:12], 12'h000};
            end else if (kind_of[i] == I_BEQ || kind_of[i] == I_BNE) begin
                span = 1 + int'(r[15:12] % 4'd6);
                if (i + span > PROG_LEN - 1) begin
                    span = PROG_LEN - 1 - i;
                end
                imm_of[i] = XLEN'(4 * span);
            end
            word_of[i] = encode(i);
        end
    endtask

    // sequential ISA model that fills the expected write list
    task automatic run_model();
        logic [XLEN-1:0] x [0:7];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            writes;
        int              pc;
        int              next_pc;
        exp_addr.delete();
        exp_data.delete();
        for (int r = 0; r < 8; r++) begin
            x[r] = '0;
        end
        pc = 0;
        while (kind_of[pc] != I_ECALL) begin
            a       = x[rs1_of[pc][2:0]];
            b       = x[rs2_of[pc][2:0]];
            res     = '0;
            writes  = 1'b1;
            next_pc = pc + 1;
            case (kind_of[pc])
                I_ADD:   res = a + b;
                I_SUB:   res = a - b;
                I_AND:   res = a & b;
                I_OR:    res = a | b;
                I_XOR:   res = a ^ b;
                I_ADDI:  res = a + imm_of[pc];
                I_LUI:   res = imm_of[pc];
                default: begin
                    writes = 1'b0;
                    if ((a == b) == (kind_of[pc] == I_BEQ)) begin
                        next_pc = pc + int'(imm_of[pc] >> 2);
                    end
                end
            endcase
            if (writes && rd_of[pc] != '0) begin
                x[rd_of[pc][2:0]] = res;
                exp_addr.push_back(rd_of[pc]);
                exp_data.push_back(res);
            end
            pc = next_pc;
        end
    endtask

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_retire(input logic [REG_ADDR_W-1:0] want_addr,
                                input logic [REG_ADDR_W-1:0] got_addr,
                                input logic [XLEN-1:0]       want_data,
                                input logic [XLEN-1:0]       got_data);
        if (got_addr !== want_addr) begin
            $display("[FAIL] t=%0t retire_addr expected %0d observed %0d",
                     $time, want_addr, got_addr);
            stop_with_failure();
        end else if (got_data !== want_data) begin
            $display("[FAIL] t=%0t retire_data expected 0x%08h observed 0x%08h",
                     $time, want_data, got_data);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s expected %b observed %b", $time, name, want, got);
            stop_with_failure();
        end
    endtask

    task automatic check_fetch_addr(input logic [XLEN-1:0] want, input logic [XLEN-1:0] got);
        if (got !== want) begin
            $display("[FAIL] t=%0t imem_addr expected 0x%08h observed 0x%08h",
                     $time, want, got);
            stop_with_failure();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("retire_valid", 1'b0, retire_valid);
        check_flag("exit", 1'b0, exit);
        check_fetch_addr(RESET_PC, imem_addr);
    endtask

    task automatic run_program(input int prog);
        int retired;
        retired = 0;
        while (!exit) begin
            @(negedge clk);
            if (retire_valid) begin
                if (exp_addr.size() == 0) begin
                    $display("program %0d retired a write after the expected list ran out",
                             prog);
                    stop_with_failure();
                end
                check_retire(exp_addr.pop_front(), retire_addr,
                             exp_data.pop_front(), retire_data);
                retired++;
            end
        end
        if (exp_addr.size() != 0) begin
            $display("program %0d raised exit with %0d writes never retired",
                     prog, exp_addr.size());
            stop_with_failure();
        end
        repeat (DRAIN) begin
            @(negedge clk);
            check_flag("retire_valid", 1'b0, retire_valid);
            check_flag("exit", 1'b1, exit);
        end
        $display("program %0d: %0d writes retired", prog, retired);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all programs finished");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        for (int p = 0; p < NUM_PROGS; p++) begin
            build_program();
            run_model();
            apply_reset();
            run_program(p);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: core_top.f
hdl/core_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/stage_link.sv
hdl/pipe_reg.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
sim/core_sva.sv
sim/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := core_tb
FILELIST  := core_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
